// ==== hw/config_rom.hex ====
// One 16-bit configuration word per line, addresses 0 to 63 in order, word 63 balances the sum
FC00
F811
F422
F033
EC44
E855
E466
E077
DC88
D899
D4AA
D0BB
CCCC
C8DD
C4EE
C0FF
BD00
B911
B522
B133
AD44
A955
A566
A177
9D88
9999
95AA
91BB
8DCC
89DD
85EE
81FF
7E00
7A11
7622
7233
6E44
6A55
6666
6277
5E88
5A99
56AA
52BB
4ECC
4ADD
46EE
42FF
3F00
3B11
3722
3333
2F44
2B55
2766
2377
1F88
1B99
17AA
13BB
0FCC
0BDD
07EE
BED9

// ==== src.f ====
+incdir+verif
hw/nic_sys_pkg.sv
hw/eeprom_pkg.sv
hw/nic_reset_seq.sv
hw/uwire_cmd_decode.sv
hw/config_rom_read.sv
hw/uwire_data_shift.sv
hw/nic_eeprom_top.sv
verif/tb_nic_eeprom.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_nic_eeprom
FILELIST  ?= src.f
SEED      ?= 80026
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST SEED BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/tb_uwire_tasks.svh ====
`ifndef TB_UWIRE_TASKS_SVH
`define TB_UWIRE_TASKS_SVH

// Reason line and fail line before the stop
task automatic abort_run(input string why);
	$display("%s", why);
	$display("TEST FAILED");
	$fatal(1, "stopped at first error");
endtask

// Compares one value with its expected value
task automatic check_value(
	input string       name,
	input logic [31:0] got,
	input logic [31:0] exp
);
	if (got !== exp)
		abort_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

// Counts cycles until nic_rst_o drops or the timeout hits
task automatic wait_rst_release(output int cycles);
	bit released;
	released = 1'b0;
	cycles = 0;
	while (!released) begin
		@(negedge nic_clk);
		cycles++;
		if (!nic_rst_o)
			released = 1'b1;
		else if (cycles > RST_TIMEOUT)
			abort_run("timeout, nic_rst_o was never released");
	end
endtask

// One SK period with the low phase first
// DO sampled one cycle before the rising edge
task automatic sk_cycle(input logic di_val, output logic do_val);
	@(negedge nic_clk);
	ee_sk_i = 1'b0;
	ee_di_i = di_val;
	repeat (sk_half - 1) @(negedge nic_clk);
	do_val = ee_do_o;
	@(negedge nic_clk);
	ee_sk_i = 1'b1;
	repeat (sk_half - 1) @(negedge nic_clk);
endtask

// CS rises with SK low
task automatic chip_select();
	@(negedge nic_clk);
	ee_sk_i = 1'b0;
	ee_di_i = 1'b0;
	ee_cs_i = 1'b1;
	repeat (sk_half) @(negedge nic_clk);
endtask

// SK low before CS drops and DO returns low
task automatic chip_deselect();
	@(negedge nic_clk);
	ee_sk_i = 1'b0;
	repeat (sk_half) @(negedge nic_clk);
	ee_cs_i = 1'b0;
	ee_di_i = 1'b0;
	repeat (2 * sk_half) @(negedge nic_clk);
	check_value("ee_do_o deselected", ee_do_o, 1'b0);
endtask

// Start bit and two opcode bits
task automatic send_header(input logic [1:0] op);
	logic do_bit;
	sk_cycle(1'b1, do_bit);
	check_value("ee_do_o start bit", do_bit, 1'b0);
	for (int i = 1; i >= 0; i--) begin
		sk_cycle(op[i], do_bit);
		check_value("ee_do_o opcode", do_bit, 1'b0);
	end
endtask

`endif

// ==== verif/tb_nic_eeprom.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_nic_eeprom;

	parameter int SEED = 80026;

	localparam int HOLD_CYCLES = 64;
	localparam int RST_TIMEOUT = 500;
	localparam logic [15:0] ROM_SUM = 16'hBABA;

	// 93C46 opcodes after the start bit
	localparam logic [1:0] OP_EXT = 2'b00;
	localparam logic [1:0] OP_WRITE = 2'b01;
	localparam logic [1:0] OP_READ = 2'b10;
	localparam logic [1:0] OP_ERASE = 2'b11;

	typedef enum logic [1:0] {
		K_READ,
		K_OTHER,
		K_REQ,
		K_UNLOCK
	} row_kind_e;

	// One transaction per row with the hold used only by reset rows
	typedef struct packed {
		row_kind_e  kind;
		logic [1:0] op;
		logic       rand_addr;
		logic [5:0] addr;
		logic [6:0] words;
		logic [6:0] hold;
	} stim_row_t;

	localparam int N_ROWS = 12;
	localparam stim_row_t STIM_TAB [N_ROWS] = '{
		'{K_READ,   OP_READ,  1'b1, 6'd0,  7'd1,  7'd0},
		'{K_READ,   OP_READ,  1'b1, 6'd0,  7'd1,  7'd0},
		'{K_READ,   OP_READ,  1'b0, 6'd62, 7'd4,  7'd0},
		'{K_REQ,    OP_READ,  1'b0, 6'd0,  7'd0,  7'd64},
		'{K_OTHER,  OP_WRITE, 1'b0, 6'd0,  7'd0,  7'd0},
		'{K_READ,   OP_READ,  1'b1, 6'd0,  7'd1,  7'd0},
		'{K_OTHER,  OP_ERASE, 1'b0, 6'd0,  7'd0,  7'd0},
		'{K_READ,   OP_READ,  1'b1, 6'd0,  7'd2,  7'd0},
		'{K_UNLOCK, OP_READ,  1'b0, 6'd0,  7'd0,  7'd64},
		'{K_OTHER,  OP_EXT,   1'b0, 6'd0,  7'd0,  7'd0},
		'{K_READ,   OP_READ,  1'b0, 6'd0,  7'd64, 7'd0},
		'{K_READ,   OP_READ,  1'b1, 6'd0,  7'd1,  7'd0}
	};

	logic nic_clk;
	logic ext_rst;
	logic clk_locked_i;
	logic reset_request_i;
	logic ee_sk_i;
	logic ee_cs_i;
	logic ee_di_i;
	logic nic_rst_o;
	logic ee_do_o;

	// Reference image of the configuration ROM
	logic [15:0] model_mem [64];
	int          sk_half;

	nic_eeprom_top dut_i (
		.nic_clk         (nic_clk),
		.ext_rst         (ext_rst),
		.clk_locked_i    (clk_locked_i),
		.reset_request_i (reset_request_i),
		.ee_sk_i         (ee_sk_i),
		.ee_cs_i         (ee_cs_i),
		.ee_di_i         (ee_di_i),
		.nic_rst_o       (nic_rst_o),
		.ee_do_o         (ee_do_o)
	);

	`include "tb_uwire_tasks.svh"

	// READ that checks each word as it comes out and sums a full pass
	task automatic read_words(input logic [5:0] start, input int count);
		logic        do_bit;
		logic [15:0] word;
		logic [15:0] sum;
		logic [5:0]  addr;
		sum = '0;
		addr = start;
		chip_select();
		send_header(OP_READ);
		for (int i = 5; i >= 0; i--) begin
			sk_cycle(start[i], do_bit);
			check_value("ee_do_o address phase", do_bit, 1'b0);
		end
		// Dummy zero ahead of the first D15 only
		sk_cycle(1'b0, do_bit);
		check_value("ee_do_o dummy bit", do_bit, 1'b0);
		for (int w = 0; w < count; w++) begin
			for (int b = 15; b >= 0; b--) begin
				sk_cycle(1'b0, do_bit);
				word[b] = do_bit;
			end
			check_value($sformatf("ee_do_o word at 0x%0h", addr), word, model_mem[addr]);
			sum = sum + word;
			addr = addr + 6'd1;
		end
		chip_deselect();
		if (count == 64)
			check_value("ROM word sum", sum, ROM_SUM);
	endtask

	// Non-read opcode followed by address and data clocks that go nowhere
	task automatic other_cmd(input logic [1:0] op);
		logic do_bit;
		chip_select();
		send_header(op);
		for (int i = 0; i < 17; i++) begin
			sk_cycle(1'($urandom), do_bit);
			check_value("ee_do_o after non-read opcode", do_bit, 1'b0);
		end
		chip_deselect();
	endtask

	// Request pulse or lock loss followed by a timed release
	task automatic apply_reset_cause(input row_kind_e kind, input int hold);
		int cycles;
		@(negedge nic_clk);
		if (kind == K_REQ) begin
			reset_request_i = 1'b1;
			@(negedge nic_clk);
			reset_request_i = 1'b0;
		end else begin
			clk_locked_i = 1'b0;
			repeat (4 + $urandom % 8) @(negedge nic_clk);
			clk_locked_i = 1'b1;
		end
		check_value("nic_rst_o asserted", nic_rst_o, 1'b1);
		wait_rst_release(cycles);
		check_value("nic_rst_o hold cycles", cycles, hold);
	endtask

	initial begin
		nic_clk = 1'b0;
		forever #5 nic_clk = ~nic_clk;
	end

	initial begin
		stim_row_t  row;
		logic [5:0] addr;
		int         cycles;
		void'($urandom(SEED));
		sk_half = 8;
		ext_rst = 1'b1;
		clk_locked_i = 1'b1;
		reset_request_i = 1'b0;
		ee_sk_i = 1'b0;
		ee_cs_i = 1'b0;
		ee_di_i = 1'b0;
		$readmemh("hw/config_rom.hex", model_mem);
		repeat (5) @(negedge nic_clk);
		ext_rst = 1'b0;
		// Power-on hold with the clock locked
		check_value("nic_rst_o after ext_rst", nic_rst_o, 1'b1);
		check_value("ee_do_o after ext_rst", ee_do_o, 1'b0);
		wait_rst_release(cycles);
		check_value("nic_rst_o power-on hold", cycles, HOLD_CYCLES);
		for (int r = 0; r < N_ROWS; r++) begin
			row = STIM_TAB[r];
			// SK half period varies per row and stays at 8 cycles or more
			sk_half = 8 + int'($urandom % 4);
			addr = row.rand_addr ? 6'($urandom) : row.addr;
			case (row.kind)
				K_READ: read_words(addr, int'(row.words));
				K_OTHER: other_cmd(row.op);
				default: apply_reset_cause(row.kind, int'(row.hold));
			endcase
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/nic_eeprom_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module nic_eeprom_top (
	input  logic nic_clk,
	input  logic ext_rst,
	input  logic clk_locked_i,
	input  logic reset_request_i,
	input  logic ee_sk_i,
	input  logic ee_cs_i,
	input  logic ee_di_i,
	output logic nic_rst_o,
	output logic ee_do_o
);

	import eeprom_pkg::*;

	logic       nic_rst;
	rom_req_t   rom_req;
	rom_rsp_t   rom_rsp;
	shift_ctl_t shift_ctl;
	logic       word_done;

	// Controller reset, also clears the EEPROM stages
	nic_reset_seq reset_seq_i (
		.nic_clk         (nic_clk),
		.ext_rst         (ext_rst),
		.clk_locked_i    (clk_locked_i),
		.reset_request_i (reset_request_i),
		.nic_rst_o       (nic_rst)
	);

	assign nic_rst_o = nic_rst;

	// Microwire command decode
	uwire_cmd_decode cmd_decode_i (
		.nic_clk     (nic_clk),
		.ext_rst     (ext_rst),
		.nic_rst_i   (nic_rst),
		.ee_sk_i     (ee_sk_i),
		.ee_cs_i     (ee_cs_i),
		.ee_di_i     (ee_di_i),
		.rom_req_o   (rom_req),
		.shift_ctl_o (shift_ctl),
		.word_done_i (word_done)
	);

	// Configuration words
	config_rom_read rom_read_i (
		.nic_clk   (nic_clk),
		.ext_rst   (ext_rst),
		.nic_rst_i (nic_rst),
		.rom_req_i (rom_req),
		.rom_rsp_o (rom_rsp)
	);

	// Serial data out on DO
	uwire_data_shift data_shift_i (
		.nic_clk     (nic_clk),
		.ext_rst     (ext_rst),
		.nic_rst_i   (nic_rst),
		.rom_rsp_i   (rom_rsp),
		.shift_ctl_i (shift_ctl),
		.word_done_o (word_done),
		.ee_do_o     (ee_do_o)
	);

endmodule

`default_nettype wire

// ==== hw/uwire_data_shift.sv ====
`default_nettype none
`timescale 1ns/100ps

module uwire_data_shift (
	input  logic                   nic_clk,
	input  logic                   ext_rst,
	input  logic                   nic_rst_i,
	input  eeprom_pkg::rom_rsp_t   rom_rsp_i,
	input  eeprom_pkg::shift_ctl_t shift_ctl_i,
	output logic                   word_done_o,
	output logic                   ee_do_o
);

	import eeprom_pkg::*;

	ee_word_t                          shreg;
	ee_word_t                          pend_word;
	logic                              pend_full;
	logic                              first_word;
	logic [$clog2(EE_WORD_BITS):0]     bit_cnt;
	logic                              do_q;

	logic load_first;
	logic load_pend;
	logic shift_go;
	logic word_end;
	logic take_pend;
	logic shift_bit;

	// First word of a command gets the dummy bit
	assign load_first = rom_rsp_i.valid && first_word;
	// Later words queue behind the current one
	assign load_pend = rom_rsp_i.valid && !first_word;
	// Shifts before any word loaded are dropped
	assign shift_go = shift_ctl_i.shift && !first_word;
	assign word_end = (bit_cnt == EE_WORD_BITS);
	assign take_pend = shift_go && word_end && pend_full;
	assign shift_bit = shift_go && !word_end;

	// Word data
	always_ff @(posedge nic_clk) begin
		if (load_first)
			shreg <= rom_rsp_i.data;
		else if (take_pend)
			shreg <= {pend_word[EE_WORD_BITS - 2:0], 1'b0};
		else if (shift_bit)
			shreg <= {shreg[EE_WORD_BITS - 2:0], 1'b0};
		if (load_pend)
			pend_word <= rom_rsp_i.data;
	end

	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			pend_full <= 1'b0;
			first_word <= 1'b1;
			bit_cnt <= '0;
			do_q <= 1'b0;
			word_done_o <= 1'b0;
		end else if (nic_rst_i || shift_ctl_i.clear) begin
			pend_full <= 1'b0;
			first_word <= 1'b1;
			bit_cnt <= '0;
			do_q <= 1'b0;
			word_done_o <= 1'b0;
		end else begin
			// Pulse with the last bit of a word on DO
			word_done_o <= shift_bit && (bit_cnt == EE_WORD_BITS - 1);
			if (load_first) begin
				// Dummy zero ahead of D15
				first_word <= 1'b0;
				bit_cnt <= '0;
				do_q <= 1'b0;
			end else if (take_pend) begin
				// MSB of the queued word, no dummy
				do_q <= pend_word[EE_WORD_BITS - 1];
				bit_cnt <= 1'b1;
				pend_full <= 1'b0;
			end else if (shift_bit) begin
				do_q <= shreg[EE_WORD_BITS - 1];
				bit_cnt <= bit_cnt + 1'b1;
			end else if (shift_go) begin
				// Ran out of words
				do_q <= 1'b0;
			end
			if (load_pend)
				pend_full <= 1'b1;
		end
	end

	assign ee_do_o = do_q;

	// Decoder never runs more than one word ahead
	a_no_pend_overrun: assert property (
		@(posedge nic_clk) disable iff (ext_rst)
		rom_rsp_i.valid |-> !pend_full
	);

endmodule

`default_nettype wire

// ==== hw/config_rom_read.sv ====
`default_nettype none
`timescale 1ns/100ps

module config_rom_read (
	input  logic                 nic_clk,
	input  logic                 ext_rst,
	input  logic                 nic_rst_i,
	input  eeprom_pkg::rom_req_t rom_req_i,
	output eeprom_pkg::rom_rsp_t rom_rsp_o
);

	import eeprom_pkg::*;

	// Configuration image, MAC address and controller defaults
	ee_word_t rom_mem [EE_WORDS];
	ee_word_t rd_data;
	logic     rd_valid;

	initial begin
		$readmemh("hw/config_rom.hex", rom_mem);
	end

	// Data path
	always_ff @(posedge nic_clk) begin
		if (rom_req_i.req)
			rd_data <= rom_mem[rom_req_i.addr];
	end

	// Valid strobe trails the request by one cycle
	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst)
			rd_valid <= 1'b0;
		else if (nic_rst_i)
			rd_valid <= 1'b0;
		else
			rd_valid <= rom_req_i.req;
	end

	assign rom_rsp_o.valid = rd_valid;
	assign rom_rsp_o.data = rd_data;

	// Fixed one-cycle latency between decoder and shifter
	a_rsp_latency: assert property (
		@(posedge nic_clk) disable iff (ext_rst)
		rom_rsp_o.valid == $past(rom_req_i.req && !nic_rst_i)
	);

endmodule

`default_nettype wire

// ==== hw/uwire_cmd_decode.sv ====
`default_nettype none
`timescale 1ns/100ps

module uwire_cmd_decode (
	input  logic                   nic_clk,
	input  logic                   ext_rst,
	input  logic                   nic_rst_i,
	input  logic                   ee_sk_i,
	input  logic                   ee_cs_i,
	input  logic                   ee_di_i,
	output eeprom_pkg::rom_req_t   rom_req_o,
	output eeprom_pkg::shift_ctl_t shift_ctl_o,
	input  logic                   word_done_i
);

	import nic_sys_pkg::*;
	import eeprom_pkg::*;

	// Pins sampled together, {sk, cs, di} per stage
	logic [SYNC_STAGES - 1:0][2:0] pin_sync;
	logic [2:0]                    pin_s;
	logic                          sk_s;
	logic                          cs_s;
	logic                          di_s;
	logic                          sk_q;
	logic                          cs_q;
	logic                          sk_rise;
	logic                          cs_rise;
	logic                          cs_fall;

	uw_state_e                        state;
	logic [$clog2(EE_ADDR_BITS) - 1:0] bit_cnt;
	logic                             op_msb;
	ee_opcode_e                       opcode;
	ee_addr_t                         addr;
	logic                             req_q;

	// Synchronizer chain and edge history
	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			pin_sync <= '0;
			sk_q <= 1'b0;
			cs_q <= 1'b0;
		end else begin
			pin_sync <= {pin_sync[SYNC_STAGES - 2:0], {ee_sk_i, ee_cs_i, ee_di_i}};
			sk_q <= sk_s;
			cs_q <= cs_s;
		end
	end

	assign pin_s = pin_sync[SYNC_STAGES - 1];
	assign sk_s = pin_s[2];
	assign cs_s = pin_s[1];
	assign di_s = pin_s[0];

	// One-cycle edge events
	assign sk_rise = sk_s && !sk_q;
	assign cs_rise = cs_s && !cs_q;
	assign cs_fall = !cs_s && cs_q;

	// Opcode as seen when its second bit arrives
	assign opcode = ee_opcode_e'({op_msb, di_s});

	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			state <= IDLE;
			bit_cnt <= '0;
			op_msb <= 1'b0;
			addr <= '0;
			req_q <= 1'b0;
			shift_ctl_o <= '0;
		end else if (nic_rst_i) begin
			state <= IDLE;
			bit_cnt <= '0;
			op_msb <= 1'b0;
			addr <= '0;
			req_q <= 1'b0;
			shift_ctl_o <= '0;
		end else begin
			// Strobes default low
			req_q <= 1'b0;
			shift_ctl_o.shift <= 1'b0;
			shift_ctl_o.clear <= cs_fall;
			// Deselect aborts any command
			if (cs_fall) begin
				state <= IDLE;
			end else begin
				case (state)
					// Wait for a fresh select
					IDLE: begin
						if (cs_rise)
							state <= START;
					end
					// Leading zeros skipped until the start bit
					START: begin
						if (sk_rise && di_s) begin
							state <= OPCODE;
							bit_cnt <= '0;
						end
					end
					OPCODE: begin
						if (sk_rise) begin
							if (bit_cnt == 0) begin
								op_msb <= di_s;
								bit_cnt <= 1'b1;
							end else if (opcode == READ) begin
								state <= ADDR;
								bit_cnt <= '0;
							end else begin
								// Write, erase and extended ops ignored
								state <= IDLE;
							end
						end
					end
					// Address MSB first
					ADDR: begin
						if (sk_rise) begin
							addr <= {addr[EE_ADDR_BITS - 2:0], di_s};
							if (bit_cnt == EE_ADDR_BITS - 1) begin
								state <= READ_OUT;
								req_q <= 1'b1;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end
					READ_OUT: begin
						shift_ctl_o.shift <= sk_rise;
						// Sequential read, wraps 63 to 0
						if (word_done_i && cs_s) begin
							addr <= addr + 1'b1;
							req_q <= 1'b1;
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// Address register already holds the requested word
	assign rom_req_o.req = req_q;
	assign rom_req_o.addr = addr;

	// Requests only come from a READ in progress
	a_req_in_read: assert property (
		@(posedge nic_clk) disable iff (ext_rst)
		rom_req_o.req |-> (state inside {ADDR, READ_OUT})
	);

endmodule

`default_nettype wire

// ==== hw/nic_reset_seq.sv ====
`default_nettype none
`timescale 1ns/100ps

module nic_reset_seq (
	input  logic nic_clk,
	input  logic ext_rst,
	input  logic clk_locked_i,
	input  logic reset_request_i,
	output logic nic_rst_o
);

	import nic_sys_pkg::*;

	rst_cnt_t hold_cnt;
	rst_cnt_t hold_cnt_nxt;
	logic     rst_cause;

	// Any cause restarts the hold period
	assign rst_cause = reset_request_i || !clk_locked_i;

	// Count saturates at the hold length
	always_comb begin
		if (rst_cause)
			hold_cnt_nxt = '0;
		else if (hold_cnt < RST_HOLD_CYCLES)
			hold_cnt_nxt = hold_cnt + 1'b1;
		else
			hold_cnt_nxt = hold_cnt;
	end

	// Reset output registered from the next count
	// so it drops on the final counting edge
	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			hold_cnt <= '0;
			nic_rst_o <= 1'b1;
		end else begin
			hold_cnt <= hold_cnt_nxt;
			nic_rst_o <= (hold_cnt_nxt < RST_HOLD_CYCLES);
		end
	end

	// Controller request always reasserts reset next cycle
	a_req_asserts_rst: assert property (
		@(posedge nic_clk) disable iff (ext_rst)
		reset_request_i |=> nic_rst_o
	);

endmodule

`default_nettype wire

// ==== hw/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

	// Microwire EEPROM geometry, 93C46 style in 16-bit mode
	localparam int EE_ADDR_BITS = 6;
	localparam int EE_WORDS = 64;
	localparam int EE_WORD_BITS = 16;

	// Word address and data word
	typedef logic [EE_ADDR_BITS - 1:0] ee_addr_t;
	typedef logic [EE_WORD_BITS - 1:0] ee_word_t;

	// Two opcode bits following the start bit
	typedef enum logic [1:0] {
		EXT   = 2'b00,
		WRITE = 2'b01,
		READ  = 2'b10,
		ERASE = 2'b11
	} ee_opcode_e;

	// Command decoder states
	typedef enum logic [2:0] {
		IDLE,
		START,
		OPCODE,
		ADDR,
		READ_OUT
	} uw_state_e;

	// Decoder to ROM, one-cycle request
	typedef struct packed {
		logic     req;
		ee_addr_t addr;
	} rom_req_t;

	// ROM to shifter, one-cycle response
	typedef struct packed {
		logic     valid;
		ee_word_t data;
	} rom_rsp_t;

	// Decoder to shifter strobes
	typedef struct packed {
		logic shift;
		logic clear;
	} shift_ctl_t;

endpackage

`default_nettype wire

// ==== hw/nic_sys_pkg.sv ====
`default_nettype none

package nic_sys_pkg;

	// Controller clocking and reset constants

	// Cycles of nic_clk the reset stays asserted
	// after the last cause goes away
	localparam int RST_HOLD_CYCLES = 64;

	// Flops in each asynchronous pin synchronizer
	localparam int SYNC_STAGES = 2;

	// Hold counter must reach RST_HOLD_CYCLES itself
	typedef logic [$clog2(RST_HOLD_CYCLES + 1) - 1:0] rst_cnt_t;

endpackage

`default_nettype wire
